/* hdl/seg_file.sv */
module seg_file #(
    parameter int                NUM_WR_PORTS = 4,
    parameter int                NUM_RD_PORTS = 4,
    parameter seg_pkg::seg_lim_t SEG_LIM_INIT = 20'hFFFFF
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  seg_pkg::seg_load_t   load [NUM_WR_PORTS],
    input  seg_pkg::seg_rename_t rename,
    input  logic                 wb_valid,
    input  seg_pkg::seg_wb_t     wb,
    input  logic                 flush,
    input  seg_pkg::seg_idx_t    rd_idx [NUM_RD_PORTS],
    output seg_pkg::seg_entry_t  rd_data [NUM_RD_PORTS]
);

    import seg_pkg::*;

    logic       slot_load_en   [NUM_SEGS];
    seg_base_t  slot_base      [NUM_SEGS];
    seg_lim_t   slot_lim       [NUM_SEGS];
    logic       slot_rename_en [NUM_SEGS];
    seg_entry_t slot_entry     [NUM_SEGS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Ports are scanned in ascending order, so the highest hit wins.
    always_comb begin
        for (int s = 0; s < NUM_SEGS; s++) begin
            slot_load_en[s] = 1'b0;
            slot_base[s]    = '0;
            slot_lim[s]     = '0;
            for (int p = 0; p < NUM_WR_PORTS; p++) begin
                if (load[p].valid && (load[p].idx == seg_idx_t'(s))) begin
                    slot_load_en[s] = 1'b1;
                    slot_base[s]    = load[p].base;
                    slot_lim[s]     = load[p].lim;
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_SEGS; s++) begin
            slot_rename_en[s] = rename.valid && (rename.idx == seg_idx_t'(s));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register slots.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Writeback goes to every slot; each one checks its own tag.
    for (genvar s = 0; s < NUM_SEGS; s++) begin : g_slot
        seg_slot #(
            .SEG_LIM_INIT (SEG_LIM_INIT)
        ) seg_slot_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .load_en    (slot_load_en[s]),
            .load_base  (slot_base[s]),
            .load_lim   (slot_lim[s]),
            .rename_en  (slot_rename_en[s]),
            .rename_tag (rename.tag),
            .wb_valid   (wb_valid),
            .wb         (wb),
            .flush      (flush),
            .entry      (slot_entry[s])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Unused indices read as zero.
    always_comb begin
        for (int r = 0; r < NUM_RD_PORTS; r++) begin
            rd_data[r] = '0;
            if (rd_idx[r] <= SEG_GS) begin
                rd_data[r] = slot_entry[rd_idx[r]];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A write to index 6 or 7 would be silently lost.
    for (genvar p = 0; p < NUM_WR_PORTS; p++) begin : g_load_chk
        a_load_idx: assert property (
            @(posedge clk) disable iff (!rst_n)
            load[p].valid |-> (load[p].idx <= SEG_GS)
        );
    end

    a_rename_idx: assert property (
        @(posedge clk) disable iff (!rst_n)
        rename.valid |-> (rename.idx <= SEG_GS)
    );

endmodule

/* hdl/seg_pkg.sv */
package seg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [15:0] seg_base_t;
    typedef logic [19:0] seg_lim_t;
    typedef logic [6:0]  ptc_tag_t;
    typedef logic [2:0]  seg_idx_t;

    // Fixed by the architecture.
    localparam int NUM_SEGS = 6;

    // Register indices, 6 and 7 unused.
    localparam seg_idx_t SEG_CS = 3'd0;
    localparam seg_idx_t SEG_DS = 3'd1;
    localparam seg_idx_t SEG_SS = 3'd2;
    localparam seg_idx_t SEG_ES = 3'd3;
    localparam seg_idx_t SEG_FS = 3'd4;
    localparam seg_idx_t SEG_GS = 3'd5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bundles.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Read-port result, 44 bits.
    typedef struct packed {
        seg_base_t base;
        seg_lim_t  lim;
        logic      pending;
        ptc_tag_t  tag;
    } seg_entry_t;

    // One direct-load port, 40 bits.
    typedef struct packed {
        logic      valid;
        seg_idx_t  idx;
        seg_base_t base;
        seg_lim_t  lim;
    } seg_load_t;

    typedef struct packed {
        logic     valid;
        seg_idx_t idx;
        ptc_tag_t tag;
    } seg_rename_t;

    // Producer result carrying a new base.
    typedef struct packed {
        ptc_tag_t  tag;
        seg_base_t base;
    } seg_wb_t;

endpackage

/* hdl/seg_slot.sv */
module seg_slot #(
    parameter seg_pkg::seg_lim_t SEG_LIM_INIT = 20'hFFFFF
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_en,
    input  seg_pkg::seg_base_t   load_base,
    input  seg_pkg::seg_lim_t    load_lim,
    input  logic                 rename_en,
    input  seg_pkg::ptc_tag_t    rename_tag,
    input  logic                 wb_valid,
    input  seg_pkg::seg_wb_t     wb,
    input  logic                 flush,
    output seg_pkg::seg_entry_t  entry
);

    import seg_pkg::*;

    seg_base_t base_q;
    seg_lim_t  lim_q;
    logic      pending_q;
    ptc_tag_t  tag_q;

    logic wb_hit;
    logic rename_ok;

    // A result only counts while its producer is still outstanding.
    assign wb_hit    = wb_valid && pending_q && (wb.tag == tag_q) && !flush;
    assign rename_ok = rename_en && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_q    <= '0;
            lim_q     <= SEG_LIM_INIT;
            pending_q <= 1'b0;
            tag_q     <= '0;
        end else begin
            // Direct load beats the writeback base.
            if (load_en) begin
                base_q <= load_base;
                lim_q  <= load_lim;
            end else if (wb_hit) begin
                base_q <= wb.base;
            end

            if (flush) begin
                pending_q <= 1'b0;
            end else if (rename_en) begin
                pending_q <= 1'b1;
            end else if (wb_hit) begin
                pending_q <= 1'b0;
            end

            if (rename_ok) begin
                tag_q <= rename_tag;
            end
        end
    end

    assign entry = '{base: base_q, lim: lim_q, pending: pending_q, tag: tag_q};

    // Pending only rises one cycle after an accepted rename.
    a_pending_from_rename: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(pending_q) |-> $past(rename_ok)
    );

endmodule

/* hdl/seg_unit.sv */
module seg_unit #(
    parameter int                NUM_WR_PORTS = 4,
    parameter int                NUM_RD_PORTS = 4,
    parameter int                WB_DEPTH     = 4,
    parameter seg_pkg::seg_lim_t SEG_LIM_INIT = 20'hFFFFF
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  seg_pkg::seg_load_t   load [NUM_WR_PORTS],
    input  seg_pkg::seg_rename_t rename,
    input  logic                 flush,
    input  logic                 wb_valid,
    input  seg_pkg::seg_wb_t     wb,
    output logic                 wb_credit,
    input  seg_pkg::seg_idx_t    rd_idx [NUM_RD_PORTS],
    output seg_pkg::seg_entry_t  rd_data [NUM_RD_PORTS]
);

    import seg_pkg::*;

    logic    wb_out_valid;
    seg_wb_t wb_out;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Writeback path.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One credit goes back per entry drained into the file.
    seg_wb_queue #(
        .WB_DEPTH (WB_DEPTH)
    ) seg_wb_queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (wb_valid),
        .in_wb     (wb),
        .out_valid (wb_out_valid),
        .out_wb    (wb_out),
        .credit    (wb_credit)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register file.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    seg_file #(
        .NUM_WR_PORTS (NUM_WR_PORTS),
        .NUM_RD_PORTS (NUM_RD_PORTS),
        .SEG_LIM_INIT (SEG_LIM_INIT)
    ) seg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .rename   (rename),
        .wb_valid (wb_out_valid),
        .wb       (wb_out),
        .flush    (flush),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

endmodule

/* hdl/seg_wb_queue.sv */
module seg_wb_queue #(
    parameter int WB_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  seg_pkg::seg_wb_t in_wb,
    output logic             out_valid,
    output seg_pkg::seg_wb_t out_wb,
    output logic             credit
);

    import seg_pkg::*;

    localparam int PTR_W = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;
    localparam int CNT_W = $clog2(WB_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    seg_wb_t mem [WB_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    logic empty;
    logic full;
    logic push;
    logic pop;

    assign empty = (count == '0);
    assign full  = (count == cnt_t'(WB_DEPTH));

    // The file never stalls, so the head leaves on every cycle it is shown.
    assign push = in_valid;
    assign pop  = !empty;

    assign out_valid = !empty;
    assign out_wb    = mem[rd_ptr];
    assign credit    = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_wb;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(WB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(WB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer credit accounting must keep us from overflowing.
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> !full
    );

endmodule

/* include/seg_tb_checks.svh */
`ifndef SEG_TB_CHECKS_SVH
`define SEG_TB_CHECKS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compare helpers for the testbench.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

int check_count = 0;
int error_count = 0;

// Whole-entry compare, fields listed on a mismatch.
task automatic check_entry(
    input string               name,
    input seg_pkg::seg_entry_t expected,
    input seg_pkg::seg_entry_t actual
);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("FAIL: %s expected 0x%h actual 0x%h", name, expected, actual);
        $display("      base exp 0x%h act 0x%h", expected.base, actual.base);
        $display("      lim  exp 0x%h act 0x%h", expected.lim, actual.lim);
        $display("      pend exp 0x%h act 0x%h", expected.pending, actual.pending);
        $display("      tag  exp 0x%h act 0x%h", expected.tag, actual.tag);
    end
endtask

// Producer-side credit total.
task automatic check_credit_count(
    input string name,
    input int    expected,
    input int    actual
);
    check_count++;
    if (actual != expected) begin
        error_count++;
        $display("FAIL: %s expected 0x%h actual 0x%h", name, expected, actual);
    end
endtask

`endif

/* sim/tb_seg_unit.sv */
module tb_seg_unit;

    import seg_pkg::*;

    localparam int       NUM_WR_PORTS   = 4;
    localparam int       NUM_RD_PORTS   = 4;
    localparam int       WB_DEPTH       = 4;
    localparam seg_lim_t SEG_LIM_INIT   = 20'hFFFFF;
    localparam int       TIMEOUT_CYCLES = 50;

    `include "seg_tb_checks.svh"

    logic        clk;
    logic        rst_n;
    seg_load_t   load [NUM_WR_PORTS];
    seg_rename_t rename;
    logic        flush;
    logic        wb_valid;
    seg_wb_t     wb;
    logic        wb_credit;
    seg_idx_t    rd_idx [NUM_RD_PORTS];
    seg_entry_t  rd_data [NUM_RD_PORTS];

    // Expected register state, producer credits and pulses seen.
    seg_entry_t model [NUM_SEGS];
    int         credits = WB_DEPTH;
    int         credit_pulses = 0;

    seg_unit #(
        .NUM_WR_PORTS (NUM_WR_PORTS),
        .NUM_RD_PORTS (NUM_RD_PORTS),
        .WB_DEPTH     (WB_DEPTH),
        .SEG_LIM_INIT (SEG_LIM_INIT)
    ) seg_unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .rename    (rename),
        .flush     (flush),
        .wb_valid  (wb_valid),
        .wb        (wb),
        .wb_credit (wb_credit),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rst_n && wb_credit) begin
            credits++;
            credit_pulses++;
        end
    end

    // Hard stop in case a test loses track of the DUT.
    initial begin
        #20000;
        $display("Simulation ran past its time limit");
        $display("FAIL: see errors above");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_model();
        for (int s = 0; s < NUM_SEGS; s++) begin
            model[s].base    = '0;
            model[s].lim     = SEG_LIM_INIT;
            model[s].pending = 1'b0;
            model[s].tag     = '0;
        end
    endtask

    task automatic record_rename(input seg_idx_t idx, input ptc_tag_t tag);
        model[idx].pending = 1'b1;
        model[idx].tag     = tag;
    endtask

    task automatic flush_model();
        for (int s = 0; s < NUM_SEGS; s++) begin
            model[s].pending = 1'b0;
        end
    endtask

    // Only a register still waiting on this tag takes the new base.
    task automatic retire_writeback(input ptc_tag_t tag, input seg_base_t base);
        for (int s = 0; s < NUM_SEGS; s++) begin
            if (model[s].pending && (model[s].tag == tag)) begin
                model[s].base    = base;
                model[s].pending = 1'b0;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drivers and waits.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Callers drive ports in ascending order, so the last call for a slot wins.
    task automatic drive_load(input int p, input seg_idx_t idx, input seg_base_t base,
                              input seg_lim_t lim);
        load[p].valid   = 1'b1;
        load[p].idx     = idx;
        load[p].base    = base;
        load[p].lim     = lim;
        model[idx].base = base;
        model[idx].lim  = lim;
    endtask

    task automatic clear_loads();
        for (int p = 0; p < NUM_WR_PORTS; p++) begin
            load[p] = '0;
        end
    endtask

    task automatic rename_for_one_cycle(input seg_idx_t idx, input ptc_tag_t tag);
        rename.valid = 1'b1;
        rename.idx   = idx;
        rename.tag   = tag;
        record_rename(idx, tag);
        next_cycle();
        rename = '0;
    endtask

    task automatic wait_for_credit();
        int waited;
        waited = 0;
        while ((credits == 0) && (waited < TIMEOUT_CYCLES)) begin
            next_cycle();
            waited++;
        end
        if (credits == 0) begin
            error_count++;
            $display("Timed out waiting for a writeback credit");
        end
    endtask

    task automatic send_writeback(input ptc_tag_t tag, input seg_base_t base);
        wait_for_credit();
        wb_valid = 1'b1;
        wb.tag   = tag;
        wb.base  = base;
        credits--;
        next_cycle();
        wb_valid = 1'b0;
    endtask

    // All credits back means the queue is empty and the file has the results.
    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while ((credits != WB_DEPTH) && (waited < TIMEOUT_CYCLES)) begin
            next_cycle();
            waited++;
        end
        if (credits != WB_DEPTH) begin
            error_count++;
            $display("Timed out waiting for the writeback queue to drain");
        end
    endtask

    // Reads all eight indices, four per cycle.
    task automatic check_model();
        int         idx;
        seg_entry_t expected;
        for (int g = 0; g < 2; g++) begin
            for (int p = 0; p < NUM_RD_PORTS; p++) begin
                rd_idx[p] = seg_idx_t'(g * NUM_RD_PORTS + p);
            end
            #2;
            for (int p = 0; p < NUM_RD_PORTS; p++) begin
                idx      = g * NUM_RD_PORTS + p;
                expected = (idx < NUM_SEGS) ? model[idx] : '0;
                check_entry($sformatf("rd_data[%0d] idx %0d", p, idx), expected, rd_data[p]);
            end
            next_cycle();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_reset_state();
        reset_model();
        check_model();
    endtask

    task automatic test_direct_load();
        drive_load(0, SEG_CS, seg_base_t'($urandom), seg_lim_t'($urandom));
        drive_load(1, SEG_DS, seg_base_t'($urandom), seg_lim_t'($urandom));
        drive_load(2, SEG_SS, seg_base_t'($urandom), seg_lim_t'($urandom));
        drive_load(3, SEG_DS, seg_base_t'($urandom), seg_lim_t'($urandom));
        next_cycle();
        clear_loads();
        drive_load(0, SEG_ES, seg_base_t'($urandom), seg_lim_t'($urandom));
        drive_load(1, SEG_FS, seg_base_t'($urandom), seg_lim_t'($urandom));
        drive_load(2, SEG_GS, seg_base_t'($urandom), seg_lim_t'($urandom));
        next_cycle();
        clear_loads();
        check_model();
    endtask

    task automatic test_rename_writeback();
        ptc_tag_t  tag;
        seg_base_t base;
        tag  = ptc_tag_t'($urandom);
        base = seg_base_t'($urandom);
        rename_for_one_cycle(SEG_DS, tag);
        check_model();
        send_writeback(tag, base);
        wait_for_drain();
        retire_writeback(tag, base);
        check_model();
        // DS waits on the tag again, so only the tag compare can drop this one.
        rename_for_one_cycle(SEG_DS, tag);
        base = seg_base_t'($urandom);
        send_writeback(tag ^ 7'h01, base);
        wait_for_drain();
        retire_writeback(tag ^ 7'h01, base);
        check_model();
    endtask

    task automatic test_credit_flow();
        seg_idx_t  regs [WB_DEPTH];
        seg_base_t bases [WB_DEPTH];
        ptc_tag_t  tag0;
        int        pulses_before;
        regs  = '{SEG_CS, SEG_SS, SEG_ES, SEG_FS};
        tag0  = ptc_tag_t'($urandom);
        for (int i = 0; i < WB_DEPTH; i++) begin
            bases[i] = seg_base_t'($urandom);
            rename_for_one_cycle(regs[i], tag0 + ptc_tag_t'(i));
        end
        pulses_before = credit_pulses;
        for (int i = 0; i < WB_DEPTH; i++) begin
            send_writeback(tag0 + ptc_tag_t'(i), bases[i]);
        end
        // Each entry leaves one cycle after it lands, so only the last is queued.
        check_credit_count("credits after burst", WB_DEPTH - 1, credits);
        wait_for_drain();
        check_credit_count("credits after drain", WB_DEPTH, credits);
        for (int i = 0; i < WB_DEPTH; i++) begin
            retire_writeback(tag0 + ptc_tag_t'(i), bases[i]);
        end
        check_model();
        check_credit_count("wb_credit pulses", WB_DEPTH, credit_pulses - pulses_before);
    endtask

    task automatic test_flush();
        ptc_tag_t  tag0;
        seg_base_t bases [3];
        tag0 = ptc_tag_t'($urandom);
        for (int i = 0; i < 3; i++) begin
            bases[i] = seg_base_t'($urandom);
        end
        rename_for_one_cycle(SEG_DS, tag0);
        rename_for_one_cycle(SEG_SS, tag0 + 7'd1);
        rename_for_one_cycle(SEG_GS, tag0 + 7'd2);
        // Flush lands as the first result enters the queue, with a rename on CS.
        flush        = 1'b1;
        rename.valid = 1'b1;
        rename.idx   = SEG_CS;
        rename.tag   = tag0 + 7'd3;
        flush_model();
        send_writeback(tag0, bases[0]);
        flush  = 1'b0;
        rename = '0;
        send_writeback(tag0 + 7'd1, bases[1]);
        send_writeback(tag0 + 7'd2, bases[2]);
        wait_for_drain();
        for (int i = 0; i < 3; i++) begin
            retire_writeback(tag0 + ptc_tag_t'(i), bases[i]);
        end
        check_model();
    endtask

    task automatic test_priority();
        ptc_tag_t  tag_old;
        ptc_tag_t  tag_new;
        seg_base_t base;
        tag_old = ptc_tag_t'($urandom);
        tag_new = tag_old ^ 7'h55;
        base    = seg_base_t'($urandom);
        rename_for_one_cycle(SEG_FS, tag_old);
        send_writeback(tag_old, base);
        // The file sees the writeback and the new rename on the same edge.
        retire_writeback(tag_old, base);
        rename_for_one_cycle(SEG_FS, tag_new);
        check_model();
        wait_for_drain();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int seed_val;
        seed_val = $urandom(32'hc83f7965);
        rst_n    = 1'b0;
        flush    = 1'b0;
        wb_valid = 1'b0;
        wb       = '0;
        rename   = '0;
        clear_loads();
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            rd_idx[p] = '0;
        end
        reset_model();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        test_reset_state();
        test_direct_load();
        test_rename_writeback();
        test_credit_flow();
        test_flush();
        test_priority();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
hdl/seg_pkg.sv
hdl/seg_slot.sv
hdl/seg_file.sv
hdl/seg_wb_queue.sv
hdl/seg_unit.sv
sim/tb_seg_unit.sv
